// File: rtl/bus_params.svh
`ifndef BUS_PARAMS_SVH
`define BUS_PARAMS_SVH

// memory map of the system bus

`define SRAM_BASE      32'h8000_0000   // first byte of the word SRAM
`define SRAM_WORDS     256             // depth of the SRAM in 32-bit words

// the two halves of the 64-bit machine timer
`define MTIME_LO_ADDR  32'ha000_0048
`define MTIME_HI_ADDR  32'ha000_004c

// response codes on the r and b channels
`define RESP_OKAY      2'd0
`define RESP_DECERR    2'd3            // no slave word behind the address

`endif

// File: rtl/bus_pkg.sv
package bus_pkg;

  typedef logic [31:0] addr_t;   // byte address
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;   // one enable bit per byte lane
  typedef logic [1:0]  resp_t;

  // read request channel
  typedef struct packed {
    addr_t addr;
  } ar_req_t;

  // write request carries address and data together
  typedef struct packed {
    addr_t addr;
    data_t data;
    strb_t strb;
  } w_req_t;

  // read response channel
  typedef struct packed {
    data_t data;
    resp_t resp;
  } r_resp_t;

  // which slave currently holds the bus grant
  typedef enum logic [1:0] {
    grant_idle,
    grant_sram,
    grant_clint
  } grant_state_t;

endpackage

// File: rtl/bus_arbiter.sv
`timescale 1ns/1ps
`include "bus_params.svh"

module bus_arbiter (
  input  logic             clock,
  input  logic             reset,
  input  logic             fetch_ar_valid,
  output logic             fetch_ar_ready,
  input  bus_pkg::ar_req_t fetch_ar,
  output logic             fetch_r_valid,
  input  logic             fetch_r_ready,
  output bus_pkg::r_resp_t fetch_r,
  input  logic             lsu_ar_valid,
  output logic             lsu_ar_ready,
  input  bus_pkg::ar_req_t lsu_ar,
  output logic             lsu_r_valid,
  input  logic             lsu_r_ready,
  output bus_pkg::r_resp_t lsu_r,
  input  logic             lsu_w_valid,
  output logic             lsu_w_ready,
  input  bus_pkg::w_req_t  lsu_w,
  output logic             lsu_b_valid,
  input  logic             lsu_b_ready,
  output bus_pkg::resp_t   lsu_b,
  output logic             sram_ar_valid,
  input  logic             sram_ar_ready,
  output bus_pkg::ar_req_t sram_ar,
  input  logic             sram_r_valid,
  output logic             sram_r_ready,
  input  bus_pkg::r_resp_t sram_r,
  output logic             sram_w_valid,
  input  logic             sram_w_ready,
  output bus_pkg::w_req_t  sram_w,
  input  logic             sram_b_valid,
  output logic             sram_b_ready,
  input  bus_pkg::resp_t   sram_b,
  output logic             clint_ar_valid,
  input  logic             clint_ar_ready,
  output bus_pkg::ar_req_t clint_ar,
  input  logic             clint_r_valid,
  output logic             clint_r_ready,
  input  bus_pkg::r_resp_t clint_r
);
  import bus_pkg::*;

  localparam logic [1:0] owner_fetch  = 2'd0;
  localparam logic [1:0] owner_lsu_rd = 2'd1;
  localparam logic [1:0] owner_lsu_wr = 2'd2;

  grant_state_t state;
  logic [1:0]   owner;          // master that holds the grant
  logic         rd_ar_valid;
  ar_req_t      rd_ar;
  logic         rd_r_ready;
  logic         rd_ar_ready;
  logic         rd_r_valid;
  r_resp_t      rd_r;
  logic         resp_done;

  // only the two mtime words live in the CLINT, every other read goes to SRAM
  function automatic grant_state_t read_target(input addr_t addr);
    if (addr == `MTIME_LO_ADDR || addr == `MTIME_HI_ADDR) return grant_clint;
    return grant_sram;
  endfunction

  assign rd_ar_valid = (owner == owner_fetch) ? fetch_ar_valid : lsu_ar_valid;
  assign rd_ar       = (owner == owner_fetch) ? fetch_ar : lsu_ar;
  assign rd_r_ready  = (owner == owner_fetch) ? fetch_r_ready : lsu_r_ready;

  always_comb begin
    sram_ar_valid  = 1'b0;
    sram_ar        = '0;
    sram_r_ready   = 1'b0;
    sram_w_valid   = 1'b0;
    sram_w         = '0;
    sram_b_ready   = 1'b0;
    clint_ar_valid = 1'b0;
    clint_ar       = '0;
    clint_r_ready  = 1'b0;
    rd_ar_ready    = 1'b0;
    rd_r_valid     = 1'b0;
    rd_r           = '0;
    lsu_w_ready    = 1'b0;
    lsu_b_valid    = 1'b0;
    lsu_b          = '0;
    case (state)
      grant_sram: begin
        if (owner == owner_lsu_wr) begin
          sram_w_valid = lsu_w_valid;
          sram_w       = lsu_w;
          lsu_w_ready  = sram_w_ready;
          lsu_b_valid  = sram_b_valid;
          lsu_b        = sram_b;
          sram_b_ready = lsu_b_ready;
        end else begin
          sram_ar_valid = rd_ar_valid;
          sram_ar       = rd_ar;
          rd_ar_ready   = sram_ar_ready;
          rd_r_valid    = sram_r_valid;
          rd_r          = sram_r;
          sram_r_ready  = rd_r_ready;
        end
      end
      grant_clint: begin
        clint_ar_valid = rd_ar_valid;
        clint_ar       = rd_ar;
        rd_ar_ready    = clint_ar_ready;
        rd_r_valid     = clint_r_valid;
        rd_r           = clint_r;
        clint_r_ready  = rd_r_ready;
      end
      default: ;
    endcase
  end

  assign fetch_ar_ready = (owner == owner_fetch) && rd_ar_ready;
  assign fetch_r_valid  = (owner == owner_fetch) && rd_r_valid;
  assign fetch_r        = (owner == owner_fetch) ? rd_r : '0;
  assign lsu_ar_ready   = (owner == owner_lsu_rd) && rd_ar_ready;
  assign lsu_r_valid    = (owner == owner_lsu_rd) && rd_r_valid;
  assign lsu_r          = (owner == owner_lsu_rd) ? rd_r : '0;

  // readies are zero outside the grant, so any handshake here is the granted response
  assign resp_done = (sram_r_valid && sram_r_ready) || (sram_b_valid && sram_b_ready) ||
                     (clint_r_valid && clint_r_ready);

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= grant_idle;
      owner <= owner_fetch;
    end else if (state == grant_idle) begin
      if (fetch_ar_valid) begin
        owner <= owner_fetch;
        state <= read_target(fetch_ar.addr);
      end else if (lsu_ar_valid) begin
        owner <= owner_lsu_rd;
        state <= read_target(lsu_ar.addr);
      end else if (lsu_w_valid) begin
        owner <= owner_lsu_wr;
        state <= grant_sram;        // the CLINT is read-only
      end
    end else if (resp_done) begin
      state <= grant_idle;
    end
  end

endmodule

// File: rtl/sram_slave.sv
`timescale 1ns/1ps
`include "bus_params.svh"

module sram_slave (
  input  logic             clock,
  input  logic             reset,
  input  logic             ar_valid,
  output logic             ar_ready,
  input  bus_pkg::ar_req_t ar,
  output logic             r_valid,
  input  logic             r_ready,
  output bus_pkg::r_resp_t r,
  input  logic             w_valid,
  output logic             w_ready,
  input  bus_pkg::w_req_t  w,
  output logic             b_valid,
  input  logic             b_ready,
  output bus_pkg::resp_t   b
);
  import bus_pkg::*;

  localparam int idx_w = $clog2(`SRAM_WORDS);

  data_t             mem [`SRAM_WORDS];
  addr_t             rd_off;
  addr_t             wr_off;
  logic              rd_hit;
  logic              wr_hit;
  logic [idx_w-1:0]  rd_idx;
  logic [idx_w-1:0]  wr_idx;
  logic              busy;
  logic              ar_fire;
  logic              w_fire;

  // addresses below the base wrap around and fall out of range
  assign rd_off = ar.addr - `SRAM_BASE;
  assign wr_off = w.addr - `SRAM_BASE;
  assign rd_hit = rd_off < (`SRAM_WORDS * 4);
  assign wr_hit = wr_off < (`SRAM_WORDS * 4);
  assign rd_idx = rd_off[idx_w+1:2];
  assign wr_idx = wr_off[idx_w+1:2];

  assign busy     = r_valid || b_valid;  // a response is still waiting for its ready
  assign ar_ready = !busy;
  assign w_ready  = !busy;
  assign ar_fire  = ar_valid && ar_ready;
  assign w_fire   = w_valid && w_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      r_valid <= 1'b0;
      b_valid <= 1'b0;
    end else begin
      if (ar_fire) begin
        r_valid <= 1'b1;
      end else if (r_valid && r_ready) begin
        r_valid <= 1'b0;
      end
      if (w_fire) begin
        b_valid <= 1'b1;
      end else if (b_valid && b_ready) begin
        b_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (ar_fire) begin
      r.data <= rd_hit ? mem[rd_idx] : '0;
      r.resp <= rd_hit ? `RESP_OKAY : `RESP_DECERR;
    end
    if (w_fire) begin
      b <= wr_hit ? `RESP_OKAY : `RESP_DECERR;
      for (int i = 0; i < 4; i++) begin
        if (wr_hit && w.strb[i]) mem[wr_idx][8*i +: 8] <= w.data[8*i +: 8];
      end
    end
  end

endmodule

// File: rtl/clint_timer.sv
`timescale 1ns/1ps
`include "bus_params.svh"

module clint_timer (
  input  logic             clock,
  input  logic             reset,
  input  logic             ar_valid,
  output logic             ar_ready,
  input  bus_pkg::ar_req_t ar,
  output logic             r_valid,
  input  logic             r_ready,
  output bus_pkg::r_resp_t r
);
  import bus_pkg::*;

  logic [63:0] mtime;
  logic        ar_fire;

  assign ar_ready = !r_valid;   // one read in flight
  assign ar_fire  = ar_valid && ar_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      mtime   <= '0;
      r_valid <= 1'b0;
    end else begin
      mtime <= mtime + 64'd1;
      if (ar_fire) begin
        r_valid <= 1'b1;
      end else if (r_valid && r_ready) begin
        r_valid <= 1'b0;
      end
    end
  end

  // the address is already decoded upstream, bit 2 picks the half
  always_ff @(posedge clock) begin
    if (ar_fire) begin
      r.data <= ar.addr[2] ? data_t'(mtime[63:32]) : data_t'(mtime[31:0]);
      r.resp <= `RESP_OKAY;
    end
  end

endmodule

// File: rtl/bus_top.sv
`timescale 1ns/1ps

module bus_top (
  input  logic             clock,
  input  logic             reset,
  input  logic             fetch_ar_valid,
  output logic             fetch_ar_ready,
  input  bus_pkg::ar_req_t fetch_ar,
  output logic             fetch_r_valid,
  input  logic             fetch_r_ready,
  output bus_pkg::r_resp_t fetch_r,
  input  logic             lsu_ar_valid,
  output logic             lsu_ar_ready,
  input  bus_pkg::ar_req_t lsu_ar,
  output logic             lsu_r_valid,
  input  logic             lsu_r_ready,
  output bus_pkg::r_resp_t lsu_r,
  input  logic             lsu_w_valid,
  output logic             lsu_w_ready,
  input  bus_pkg::w_req_t  lsu_w,
  output logic             lsu_b_valid,
  input  logic             lsu_b_ready,
  output bus_pkg::resp_t   lsu_b
);
  import bus_pkg::*;

  logic    sram_ar_valid, sram_ar_ready, sram_r_valid, sram_r_ready;
  logic    sram_w_valid, sram_w_ready, sram_b_valid, sram_b_ready;
  logic    clint_ar_valid, clint_ar_ready, clint_r_valid, clint_r_ready;
  ar_req_t sram_ar;
  ar_req_t clint_ar;
  r_resp_t sram_r;
  r_resp_t clint_r;
  w_req_t  sram_w;
  resp_t   sram_b;

  bus_arbiter u_arbiter (.*);

  sram_slave u_sram (
    .clock, .reset,
    .ar_valid(sram_ar_valid), .ar_ready(sram_ar_ready), .ar(sram_ar),
    .r_valid(sram_r_valid), .r_ready(sram_r_ready), .r(sram_r),
    .w_valid(sram_w_valid), .w_ready(sram_w_ready), .w(sram_w),
    .b_valid(sram_b_valid), .b_ready(sram_b_ready), .b(sram_b)
  );

  clint_timer u_clint (
    .clock, .reset,
    .ar_valid(clint_ar_valid), .ar_ready(clint_ar_ready), .ar(clint_ar),
    .r_valid(clint_r_valid), .r_ready(clint_r_ready), .r(clint_r)
  );

endmodule

// File: tb/bus_sva.sv
`timescale 1ns/1ps

module bus_sva (
  input logic                  clock,
  input logic                  reset,
  input bus_pkg::grant_state_t state,
  input logic                  sram_r_valid,
  input logic                  sram_b_valid,
  input logic                  clint_r_valid,
  input logic                  fetch_r_valid,
  input logic                  fetch_r_ready,
  input bus_pkg::r_resp_t      fetch_r,
  input logic                  lsu_r_valid,
  input logic                  lsu_r_ready,
  input bus_pkg::r_resp_t      lsu_r,
  input logic                  lsu_b_valid,
  input logic                  lsu_b_ready,
  input bus_pkg::resp_t        lsu_b
);
  import bus_pkg::*;

  // one slave response in flight at a time
  slave_valid_onehot: assert property (@(posedge clock) disable iff (reset)
    $onehot0({sram_r_valid, sram_b_valid, clint_r_valid}))
    else $error("more than one slave response valid");

  fetch_r_stable: assert property (@(posedge clock) disable iff (reset)
    fetch_r_valid && !fetch_r_ready |=> fetch_r_valid && $stable(fetch_r))
    else $error("fetch read response changed while stalled");

  lsu_r_stable: assert property (@(posedge clock) disable iff (reset)
    lsu_r_valid && !lsu_r_ready |=> lsu_r_valid && $stable(lsu_r))
    else $error("lsu read response changed while stalled");

  lsu_b_stable: assert property (@(posedge clock) disable iff (reset)
    lsu_b_valid && !lsu_b_ready |=> lsu_b_valid && $stable(lsu_b))
    else $error("lsu write response changed while stalled");

  // a released grant leaves no slave response waiting
  idle_no_response: assert property (@(posedge clock) disable iff (reset)
    state == grant_idle |-> !sram_r_valid && !sram_b_valid && !clint_r_valid)
    else $error("slave response valid while the arbiter is idle");

endmodule

bind bus_arbiter bus_sva sva0 (
  .clock, .reset, .state,
  .sram_r_valid, .sram_b_valid, .clint_r_valid,
  .fetch_r_valid, .fetch_r_ready, .fetch_r,
  .lsu_r_valid, .lsu_r_ready, .lsu_r,
  .lsu_b_valid, .lsu_b_ready, .lsu_b
);

// File: tb/bus_tb.sv
`timescale 1ns/1ps
`include "bus_params.svh"

module bus_tb;
  import bus_pkg::*;

  localparam int num_entries = 15;
  localparam logic [1:0] op_fetch_rd = 2'd0;
  localparam logic [1:0] op_lsu_rd   = 2'd1;
  localparam logic [1:0] op_lsu_wr   = 2'd2;

  typedef struct packed {
    logic [1:0] op;
    addr_t      addr;
    data_t      data;
    strb_t      strb;
    data_t      exp_data;
    resp_t      exp_resp;
  } entry_t;

  logic    clock;
  logic    reset;
  logic    fetch_ar_valid, fetch_ar_ready, fetch_r_valid, fetch_r_ready;
  logic    lsu_ar_valid, lsu_ar_ready, lsu_r_valid, lsu_r_ready;
  logic    lsu_w_valid, lsu_w_ready, lsu_b_valid, lsu_b_ready;
  ar_req_t fetch_ar, lsu_ar;
  r_resp_t fetch_r, lsu_r;
  w_req_t  lsu_w;
  resp_t   lsu_b;

  entry_t  table_mem [num_entries];
  data_t   sb_mem [`SRAM_WORDS];  // mirror of the SRAM contents
  integer  seed = 32'hbf4877d4;
  int      seq = 0;               // completion order of responses

  bus_top dut0 (.*);

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  initial begin
    #((num_entries + 4) * 20 * 20);
    $display("Timeout: the bus did not finish the transactions in time");
    $display("Errors found");
    $fatal(1, "watchdog expired");
  end

  task automatic check(input bit ok, input string msg);
    assert (ok) else begin
      $display("Error at time %0t: %s", $time, msg);
      $display("Errors found");
      $fatal(1, "check failed");
    end
  endtask

  function automatic bit sram_hit(input addr_t a);
    return (a - `SRAM_BASE) < (`SRAM_WORDS * 4);
  endfunction

  function automatic int sram_index(input addr_t a);
    return int'((a - `SRAM_BASE) >> 2);
  endfunction

  function automatic r_resp_t model_read(input addr_t a);
    r_resp_t e;
    e.data = sram_hit(a) ? sb_mem[sram_index(a)] : '0;
    e.resp = sram_hit(a) ? `RESP_OKAY : `RESP_DECERR;
    return e;
  endfunction

  function automatic int stall_cycles();
    return int'($unsigned($random(seed)) % 4);
  endfunction

  task automatic fetch_read(input addr_t a, output r_resp_t rsp, output int ord);
    int n;
    n = stall_cycles();
    @(posedge clock);
    #1 fetch_ar_valid = 1'b1;
    fetch_ar.addr = a;
    fetch_r_ready = (n == 0);
    do @(negedge clock); while (!fetch_ar_ready);
    @(posedge clock);
    #1 fetch_ar_valid = 1'b0;
    fetch_ar = '0;
    do @(negedge clock); while (!fetch_r_valid);
    if (n > 0) begin
      repeat (n) @(posedge clock);
      #1 fetch_r_ready = 1'b1;
      @(negedge clock);
    end
    rsp = fetch_r;
    ord = seq++;
    @(posedge clock);
    #1 fetch_r_ready = 1'b0;
    @(negedge clock);
    check(!fetch_r_valid, "fetch read response delivered twice");
  endtask

  task automatic lsu_read(input addr_t a, output r_resp_t rsp, output int ord);
    int n;
    n = stall_cycles();
    @(posedge clock);
    #1 lsu_ar_valid = 1'b1;
    lsu_ar.addr = a;
    lsu_r_ready = (n == 0);
    do @(negedge clock); while (!lsu_ar_ready);
    @(posedge clock);
    #1 lsu_ar_valid = 1'b0;
    lsu_ar = '0;
    do @(negedge clock); while (!lsu_r_valid);
    if (n > 0) begin
      repeat (n) @(posedge clock);
      #1 lsu_r_ready = 1'b1;
      @(negedge clock);
    end
    rsp = lsu_r;
    ord = seq++;
    @(posedge clock);
    #1 lsu_r_ready = 1'b0;
    @(negedge clock);
    check(!lsu_r_valid, "lsu read response delivered twice");
  endtask

  task automatic lsu_write(input addr_t a, input data_t d, input strb_t s,
                           output resp_t rsp, output int ord);
    int n;
    n = stall_cycles();
    @(posedge clock);
    #1 lsu_w_valid = 1'b1;
    lsu_w.addr = a;
    lsu_w.data = d;
    lsu_w.strb = s;
    lsu_b_ready = (n == 0);
    do @(negedge clock); while (!lsu_w_ready);
    @(posedge clock);
    #1 lsu_w_valid = 1'b0;
    lsu_w = '0;
    do @(negedge clock); while (!lsu_b_valid);
    if (n > 0) begin
      repeat (n) @(posedge clock);
      #1 lsu_b_ready = 1'b1;
      @(negedge clock);
    end
    rsp = lsu_b;
    ord = seq++;
    @(posedge clock);
    #1 lsu_b_ready = 1'b0;
    @(negedge clock);
    check(!lsu_b_valid, "lsu write response delivered twice");
  endtask

  // merge the enabled bytes into the mirror, as the SRAM does
  task automatic model_write(input addr_t a, input data_t d, input strb_t s);
    if (sram_hit(a)) begin
      for (int i = 0; i < 4; i++) begin
        if (s[i]) sb_mem[sram_index(a)][8*i +: 8] = d[8*i +: 8];
      end
    end
  endtask

  initial begin
    r_resp_t rr, rr2;
    resp_t   br;
    data_t   last_lo;
    int      o1, o2, o3;
    entry_t  e;
    table_mem[0]  = '{op_lsu_wr,   32'h8000_0000, 32'hdead_beef, 4'hf, 32'h0,         `RESP_OKAY};
    table_mem[1]  = '{op_lsu_wr,   32'h8000_0004, 32'h1234_5678, 4'hf, 32'h0,         `RESP_OKAY};
    table_mem[2]  = '{op_fetch_rd, 32'h8000_0000, 32'h0,         4'h0, 32'hdead_beef, `RESP_OKAY};
    table_mem[3]  = '{op_lsu_rd,   32'h8000_0004, 32'h0,         4'h0, 32'h1234_5678, `RESP_OKAY};
    table_mem[4]  = '{op_lsu_wr,   32'h8000_0000, 32'ha5a5_a5a5, 4'h5, 32'h0,         `RESP_OKAY};
    table_mem[5]  = '{op_lsu_wr,   32'h8000_0004, 32'h00ff_0000, 4'h4, 32'h0,         `RESP_OKAY};
    table_mem[6]  = '{op_fetch_rd, 32'h8000_0000, 32'h0,         4'h0, 32'hdea5_bea5, `RESP_OKAY};
    table_mem[7]  = '{op_lsu_rd,   32'h8000_0004, 32'h0,         4'h0, 32'h12ff_5678, `RESP_OKAY};
    table_mem[8]  = '{op_lsu_wr,   32'h9000_0000, 32'hffff_ffff, 4'hf, 32'h0,        `RESP_DECERR};
    table_mem[9]  = '{op_lsu_rd,   32'h7fff_fffc, 32'h0,         4'h0, 32'h0,        `RESP_DECERR};
    table_mem[10] = '{op_fetch_rd, 32'h8000_0400, 32'h0,         4'h0, 32'h0,        `RESP_DECERR};
    table_mem[11] = '{op_lsu_rd,   32'h8000_0000, 32'h0,         4'h0, 32'hdea5_bea5, `RESP_OKAY};
    // mtime has not reached the high word this early
    table_mem[12] = '{op_lsu_rd,   `MTIME_HI_ADDR, 32'h0,        4'h0, 32'h0,         `RESP_OKAY};
    table_mem[13] = '{op_lsu_rd,   `MTIME_LO_ADDR, 32'h0,        4'h0, 32'h0,         `RESP_OKAY};
    table_mem[14] = '{op_lsu_rd,   `MTIME_LO_ADDR, 32'h0,        4'h0, 32'h0,         `RESP_OKAY};
    last_lo = '0;
    reset = 1'b1;
    fetch_ar_valid = 1'b0;
    fetch_ar = '0;
    fetch_r_ready = 1'b0;
    lsu_ar_valid = 1'b0;
    lsu_ar = '0;
    lsu_r_ready = 1'b0;
    lsu_w_valid = 1'b0;
    lsu_w = '0;
    lsu_b_ready = 1'b0;
    repeat (5) @(posedge clock);
    #1 reset = 1'b0;

    for (int k = 0; k < num_entries; k++) begin
      e = table_mem[k];
      if (e.op == op_lsu_wr) begin
        lsu_write(e.addr, e.data, e.strb, br, o1);
        check(br === e.exp_resp,
              $sformatf("entry %0d write resp %0d expected %0d", k, br, e.exp_resp));
        model_write(e.addr, e.data, e.strb);
      end else begin
        if (e.op == op_fetch_rd) fetch_read(e.addr, rr, o1);
        else lsu_read(e.addr, rr, o1);
        if (e.addr == `MTIME_LO_ADDR) begin
          check(rr.resp === e.exp_resp && rr.data > last_lo,
                $sformatf("entry %0d mtime low %h not above %h", k, rr.data, last_lo));
          last_lo = rr.data;
        end else begin
          check(rr.data === e.exp_data && rr.resp === e.exp_resp,
                $sformatf("entry %0d read %h/%0d expected %h/%0d",
                k, rr.data, rr.resp, e.exp_data, e.exp_resp));
        end
      end
    end

    // both masters at once, with an lsu write queued behind the lsu read
    fork
      fetch_read(32'h8000_0000, rr, o1);
      lsu_read(32'h8000_0004, rr2, o2);
      lsu_write(32'h8000_0008, 32'hcafe_f00d, 4'hf, br, o3);
    join
    model_write(32'h8000_0008, 32'hcafe_f00d, 4'hf);
    check(o1 < o2 && o2 < o3, $sformatf("response order %0d %0d %0d", o1, o2, o3));
    check(rr === model_read(32'h8000_0000), $sformatf("concurrent fetch read %h", rr.data));
    check(rr2 === model_read(32'h8000_0004), $sformatf("concurrent lsu read %h", rr2.data));
    check(br === `RESP_OKAY, $sformatf("concurrent write resp %0d", br));
    lsu_read(32'h8000_0008, rr, o1);
    check(rr === model_read(32'h8000_0008), $sformatf("read after write %h", rr.data));

    $display("No errors");
    $finish;
  end

endmodule

// File: sources.f
+incdir+rtl
rtl/bus_pkg.sv
rtl/bus_arbiter.sv
rtl/sram_slave.sv
rtl/clint_timer.sv
rtl/bus_top.sv
tb/bus_sva.sv
tb/bus_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= bus_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FLAGS     ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) -f sources.f --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Errors found" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "No errors" $(LOG) || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
